//--- Makefile
TOP := tb_id_ex
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)
	verilator --lint-only +incdir+common common/isa_pkg.sv common/pipe_pkg.sv \
		decode/control_unit.sv decode/general_reg.sv execute/id_ex_reg.sv \
		execute/forwarding_unit.sv execute/execute_unit.sv src/hazard_unit.sv \
		src/id_ex_top.sv --top-module id_ex_top

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- common/isa_pkg.sv
`include "pipeline_config.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,                   // operation picked by funct
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_nor = 6'h27,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [`ALU_CONTROL_WIDTH-1:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_nor, alu_slt, alu_sll, alu_srl,
        alu_pass_a                          // operand 1 straight through
    } alu_op_e;

    // low half of an r-type word
    typedef struct packed {
        logic [`REGISTER_SIZE-1:0] rd;
        logic [4:0]                shamt;
        funct_e                    funct;
    } r_low_t;

    typedef union packed {
        r_low_t      r;                     // rd, shamt, funct
        logic [15:0] imm16;                 // i-type immediate
    } instr_low_u;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REGISTER_SIZE-1:0] rs;
        logic [`REGISTER_SIZE-1:0] rt;
        instr_low_u                low;
    } instr_fields_t;

endpackage

//--- common/pipe_pkg.sv
`include "pipeline_config.svh"

package pipe_pkg;

    localparam int mem_write_bit = 0;       // mem_control bit positions
    localparam int mem_read_bit  = 1;

    typedef struct packed {
        logic [`ISA_WIDTH-1:0] instruction;
        logic [`ISA_WIDTH-1:0] pc_4;
        logic                  no_op;       // fetch slot holds nothing
    } if_id_t;

    typedef struct packed {
        logic                      reg_write_enable;
        logic [1:0]                mem_control;
        isa_pkg::alu_op_e          alu_control;
        logic                      immediate_instruction;
        logic                      jump_instruction;
        logic                      branch_instruction;
        logic                      condition_satisfied;   // beq / bne outcome
        logic                      link;                  // jal, write pc_4
        logic [`ISA_WIDTH-1:0]     sign_extend_result;
        logic [`REGISTER_SIZE-1:0] src_reg_1;             // 0 when unused
        logic [`REGISTER_SIZE-1:0] src_reg_2;
        logic [`REGISTER_SIZE-1:0] dest_reg;
    } decode_t;

    typedef struct packed {
        logic                      no_op;
        logic [`ISA_WIDTH-1:0]     pc_4;
        logic                      reg_write_enable;
        logic [1:0]                mem_control;
        isa_pkg::alu_op_e          alu_control;
        logic                      link;
        logic [`ISA_WIDTH-1:0]     operand_1;
        logic [`ISA_WIDTH-1:0]     operand_2;
        logic [`ISA_WIDTH-1:0]     store_data;
        logic [`REGISTER_SIZE-1:0] src_reg_1;
        logic [`REGISTER_SIZE-1:0] src_reg_2;
        logic [`REGISTER_SIZE-1:0] dest_reg;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        logic                      reg_write_enable;
        logic [1:0]                mem_control;
        logic [`REGISTER_SIZE-1:0] dest_reg;
        logic [`ISA_WIDTH-1:0]     result;      // alu result or load / store address
        logic [`ISA_WIDTH-1:0]     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                      write_enable;
        logic [`REGISTER_SIZE-1:0] dest_reg;
        logic [`ISA_WIDTH-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic hold;                         // drop id result, keep id/ex
        logic no_op;                        // bubble into ex
    } hazard_control_t;

endpackage

//--- common/pipeline_config.svh
`ifndef PIPELINE_CONFIG_SVH
`define PIPELINE_CONFIG_SVH

// data path and instruction word width
`define ISA_WIDTH         32

// register index width, 32 registers
`define REGISTER_SIZE     5
`define REGISTER_COUNT    (1 << `REGISTER_SIZE)

// index field of j / jal
`define ADDRESS_WIDTH     26

// alu operation code width
`define ALU_CONTROL_WIDTH 4

`endif

//--- decode/control_unit.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module control_unit (
    input  logic [`ISA_WIDTH-1:0] instruction,
    input  logic [`ISA_WIDTH-1:0] reg_1,        // rs value, bypassed
    input  logic [`ISA_WIDTH-1:0] reg_2,        // rt value, bypassed
    output pipe_pkg::decode_t     decode
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_fields_t f;

    assign f = instr_fields_t'(instruction);

    always_comb begin
        decode                    = '0;                     // unknown opcode acts as a nop
        decode.alu_control        = alu_add;
        decode.sign_extend_result = {{(`ISA_WIDTH-16){f.low.imm16[15]}}, f.low.imm16};
        decode.src_reg_1          = f.rs;
        case (f.opcode)
            op_rtype: begin
                decode.reg_write_enable = 1'b1;
                decode.src_reg_2        = f.rt;
                decode.dest_reg         = f.low.r.rd;
                case (f.low.r.funct)
                    fn_add: decode.alu_control = alu_add;
                    fn_sub: decode.alu_control = alu_sub;
                    fn_and: decode.alu_control = alu_and;
                    fn_or:  decode.alu_control = alu_or;
                    fn_xor: decode.alu_control = alu_xor;
                    fn_nor: decode.alu_control = alu_nor;
                    fn_slt: decode.alu_control = alu_slt;
                    fn_sll, fn_srl: begin
                        // shifted value is rt, shamt rides in the immediate
                        decode.alu_control           = (f.low.r.funct == fn_sll) ? alu_sll
                                                                                 : alu_srl;
                        decode.immediate_instruction = 1'b1;
                        decode.src_reg_1             = f.rt;
                        decode.src_reg_2             = '0;
                    end
                    default: decode.reg_write_enable = 1'b0;  // unsupported funct
                endcase
            end
            op_addi, op_slti, op_andi, op_ori: begin
                decode.reg_write_enable      = 1'b1;
                decode.immediate_instruction = 1'b1;
                decode.dest_reg              = f.rt;
                decode.alu_control           = (f.opcode == op_slti) ? alu_slt :
                                               (f.opcode == op_andi) ? alu_and :
                                               (f.opcode == op_ori)  ? alu_or  : alu_add;
            end
            op_lw: begin
                decode.reg_write_enable            = 1'b1;
                decode.immediate_instruction       = 1'b1;
                decode.mem_control[mem_read_bit]   = 1'b1;
                decode.dest_reg                    = f.rt;
            end
            op_sw: begin
                decode.immediate_instruction       = 1'b1;
                decode.mem_control[mem_write_bit]  = 1'b1;
                decode.src_reg_2                   = f.rt;   // store data source
            end
            op_beq, op_bne: begin
                decode.branch_instruction  = 1'b1;
                decode.src_reg_2           = f.rt;
                decode.condition_satisfied = (reg_1 == reg_2) ^ (f.opcode == op_bne);
            end
            op_j, op_jal: begin
                decode.jump_instruction = 1'b1;
                decode.src_reg_1        = '0;               // target is not a register
                if (f.opcode == op_jal) begin
                    decode.link             = 1'b1;
                    decode.reg_write_enable = 1'b1;
                    decode.alu_control      = alu_pass_a;
                    decode.dest_reg         = '1;           // r31
                end
            end
            default: ;
        endcase
    end

endmodule

//--- decode/general_reg.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module general_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`REGISTER_SIZE-1:0] src_reg_1,
    input  logic [`REGISTER_SIZE-1:0] src_reg_2,
    input  pipe_pkg::wb_t             wb,
    output logic [`ISA_WIDTH-1:0]     reg_1,
    output logic [`ISA_WIDTH-1:0]     reg_2
);
    logic [`ISA_WIDTH-1:0] regs [`REGISTER_COUNT];

    // r0 reads zero, a same-cycle write-back wins over the array
    function automatic logic [`ISA_WIDTH-1:0] read_port(input logic [`REGISTER_SIZE-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb.write_enable && wb.dest_reg == idx)
            return wb.data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REGISTER_COUNT; i++)
                regs[i] <= '0;
        end else if (wb.write_enable && wb.dest_reg != '0) begin
            regs[wb.dest_reg] <= wb.data;               // writes to r0 dropped
        end
    end

    always_comb begin
        reg_1 = read_port(src_reg_1);
        reg_2 = read_port(src_reg_2);
    end

endmodule

//--- execute/execute_unit.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module execute_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pipe_pkg::id_ex_t      id_ex,
    input  logic [`ISA_WIDTH-1:0] operand_1,      // forwarded
    input  logic [`ISA_WIDTH-1:0] operand_2,
    input  logic [`ISA_WIDTH-1:0] store_data,
    output pipe_pkg::ex_mem_t     ex_mem
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int shamt_width = $clog2(`ISA_WIDTH);

    logic [`ISA_WIDTH-1:0] alu_result;
    logic [shamt_width-1:0] shamt;

    assign shamt = operand_2[6 +: shamt_width];     // instruction bits 10:6

    always_comb begin
        case (id_ex.alu_control)
            alu_sub:    alu_result = operand_1 - operand_2;
            alu_and:    alu_result = operand_1 & operand_2;
            alu_or:     alu_result = operand_1 | operand_2;
            alu_xor:    alu_result = operand_1 ^ operand_2;
            alu_nor:    alu_result = ~(operand_1 | operand_2);
            alu_slt:    alu_result = {{(`ISA_WIDTH-1){1'b0}},
                                      $signed(operand_1) < $signed(operand_2)};
            alu_sll:    alu_result = operand_1 << shamt;
            alu_srl:    alu_result = operand_1 >> shamt;
            alu_pass_a: alu_result = operand_1;
            default:    alu_result = operand_1 + operand_2;  // add, also lw / sw address
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid            <= 1'b0;
            ex_mem.reg_write_enable <= 1'b0;
            ex_mem.mem_control      <= '0;
        end else begin
            ex_mem.valid            <= !id_ex.no_op;
            ex_mem.reg_write_enable <= id_ex.reg_write_enable && !id_ex.no_op;
            ex_mem.mem_control      <= id_ex.no_op ? 2'b00 : id_ex.mem_control;  // bubble touches no memory
            ex_mem.dest_reg         <= id_ex.dest_reg;
            ex_mem.result           <= id_ex.link ? id_ex.pc_4 : alu_result;   // jal return address
            ex_mem.store_data       <= store_data;
        end
    end

endmodule

//--- execute/forwarding_unit.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module forwarding_unit (
    input  pipe_pkg::id_ex_t      id_ex,
    input  pipe_pkg::ex_mem_t     ex_mem,
    input  pipe_pkg::wb_t         wb,
    output logic [`ISA_WIDTH-1:0] operand_1,
    output logic [`ISA_WIDTH-1:0] operand_2,
    output logic [`ISA_WIDTH-1:0] store_data
);
    import pipe_pkg::*;

    logic ex_mem_usable;

    // a load result is not known until write-back
    assign ex_mem_usable = ex_mem.valid && ex_mem.reg_write_enable
                        && !ex_mem.mem_control[mem_read_bit];

    function automatic logic [`ISA_WIDTH-1:0] pick(input logic [`REGISTER_SIZE-1:0] idx,
                                                   input logic [`ISA_WIDTH-1:0]     stored);
        if (idx == '0)
            return stored;                                  // r0 never forwarded
        if (ex_mem_usable && ex_mem.dest_reg == idx)
            return ex_mem.result;                           // youngest first
        if (wb.write_enable && wb.dest_reg == idx)
            return wb.data;
        return stored;
    endfunction

    always_comb begin
        operand_1  = pick(id_ex.src_reg_1, id_ex.operand_1);
        // store keeps its immediate offset, rt goes to store_data only
        operand_2  = id_ex.mem_control[mem_write_bit] ? id_ex.operand_2
                                                      : pick(id_ex.src_reg_2, id_ex.operand_2);
        store_data = pick(id_ex.src_reg_2, id_ex.store_data);
    end

endmodule

//--- execute/id_ex_reg.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module id_ex_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pipe_pkg::hazard_control_t hazard_control,
    input  logic                      id_no_op,       // fetch slot empty
    input  logic [`ISA_WIDTH-1:0]     pc_4,
    input  logic [`ISA_WIDTH-1:0]     instruction,    // for the jump index
    input  pipe_pkg::decode_t         decode,
    input  logic [`ISA_WIDTH-1:0]     reg_1,
    input  logic [`ISA_WIDTH-1:0]     reg_2,
    output pipe_pkg::id_ex_t          id_ex,
    output logic                      pc_offset       // branch taken, one cycle after id
);
    import isa_pkg::*;
    import pipe_pkg::*;

    id_ex_t next;
    logic   shift_op;

    assign shift_op = decode.alu_control inside {alu_sll, alu_srl};

    always_comb begin
        next.no_op            = id_no_op;
        next.pc_4             = pc_4;
        next.reg_write_enable = decode.reg_write_enable;
        next.mem_control      = decode.mem_control;
        next.alu_control      = decode.alu_control;
        next.link             = decode.link;
        // jump target is the pc_4 region plus the word index
        next.operand_1        = decode.jump_instruction
                              ? {pc_4[`ISA_WIDTH-1:`ADDRESS_WIDTH+2],
                                 instruction[`ADDRESS_WIDTH-1:0], 2'b00}
                              : (shift_op ? reg_2 : reg_1);   // shifts work on rt
        next.operand_2        = decode.immediate_instruction ? decode.sign_extend_result : reg_2;
        next.store_data       = reg_2;
        next.src_reg_1        = decode.src_reg_1;
        // stores keep rt so store data still forwards
        next.src_reg_2        = (decode.immediate_instruction && !decode.mem_control[mem_write_bit])
                              ? '0 : decode.src_reg_2;
        next.dest_reg         = decode.dest_reg;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.no_op            <= 1'b1;             // ex starts empty
            id_ex.reg_write_enable <= 1'b0;
            id_ex.mem_control      <= '0;
            pc_offset              <= 1'b0;
        end else begin
            if (!hazard_control.hold)
                id_ex <= next;
            id_ex.no_op <= hazard_control.no_op | id_no_op;   // every cycle, also under hold
            // a held branch reports once it really leaves id
            pc_offset   <= !hazard_control.hold && !id_no_op
                        && decode.branch_instruction && decode.condition_satisfied;
        end
    end

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::decode_t         decode,
    input  logic                      if_no_op,
    input  pipe_pkg::id_ex_t          id_ex,
    input  pipe_pkg::ex_mem_t         ex_mem,
    output pipe_pkg::hazard_control_t hazard_control,
    output logic                      stall
);
    import pipe_pkg::*;

    logic id_ex_writes, ex_mem_writes;
    logic id_ex_match, ex_mem_match;
    logic load_use, branch_wait;

    // r0 destinations are excluded, so a zero source never matches
    assign id_ex_writes  = !id_ex.no_op && id_ex.reg_write_enable && id_ex.dest_reg != '0;
    assign ex_mem_writes = ex_mem.valid && ex_mem.reg_write_enable && ex_mem.dest_reg != '0;

    assign id_ex_match  = id_ex_writes && (decode.src_reg_1 == id_ex.dest_reg
                                        || decode.src_reg_2 == id_ex.dest_reg);
    assign ex_mem_match = ex_mem_writes && (decode.src_reg_1 == ex_mem.dest_reg
                                         || decode.src_reg_2 == ex_mem.dest_reg);

    assign load_use    = id_ex_match && id_ex.mem_control[mem_read_bit];
    // branch compares in id, so it waits until the value is in the register file
    assign branch_wait = decode.branch_instruction && (id_ex_match || ex_mem_match);

    assign stall                = !if_no_op && (load_use || branch_wait);
    assign hazard_control.hold  = stall;
    assign hazard_control.no_op = stall;

endmodule

//--- src/id_ex_top.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module id_ex_top (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::if_id_t  if_id,
    input  pipe_pkg::wb_t     wb,
    output pipe_pkg::ex_mem_t ex_mem,
    output logic              pc_offset,
    output logic              stall
);
    import isa_pkg::*;
    import pipe_pkg::*;

    instr_fields_t         fields;
    decode_t               decode;
    hazard_control_t       hazard_control;
    id_ex_t                id_ex;
    logic [`ISA_WIDTH-1:0] reg_1, reg_2;
    logic [`ISA_WIDTH-1:0] fwd_operand_1, fwd_operand_2, fwd_store_data;

    assign fields = instr_fields_t'(if_id.instruction);

    general_reg u_general_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_reg_1 (fields.rs),                     // raw fields, decode picks what it needs
        .src_reg_2 (fields.rt),
        .wb        (wb),
        .reg_1     (reg_1),
        .reg_2     (reg_2)
    );

    control_unit u_control_unit (
        .instruction (if_id.instruction),
        .reg_1       (reg_1),
        .reg_2       (reg_2),
        .decode      (decode)
    );

    hazard_unit u_hazard_unit (
        .decode         (decode),
        .if_no_op       (if_id.no_op),
        .id_ex          (id_ex),
        .ex_mem         (ex_mem),
        .hazard_control (hazard_control),
        .stall          (stall)
    );

    id_ex_reg u_id_ex_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .hazard_control (hazard_control),
        .id_no_op       (if_id.no_op),
        .pc_4           (if_id.pc_4),
        .instruction    (if_id.instruction),
        .decode         (decode),
        .reg_1          (reg_1),
        .reg_2          (reg_2),
        .id_ex          (id_ex),
        .pc_offset      (pc_offset)
    );

    forwarding_unit u_forwarding_unit (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .wb         (wb),
        .operand_1  (fwd_operand_1),
        .operand_2  (fwd_operand_2),
        .store_data (fwd_store_data)
    );

    execute_unit u_execute_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .operand_1  (fwd_operand_1),
        .operand_2  (fwd_operand_2),
        .store_data (fwd_store_data),
        .ex_mem     (ex_mem)
    );

endmodule

//--- tb.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decode/control_unit.sv
decode/general_reg.sv
execute/id_ex_reg.sv
execute/forwarding_unit.sv
execute/execute_unit.sv
src/hazard_unit.sv
src/id_ex_top.sv
tests/tb_id_ex.sv

//--- tests/id_ex_trace.txt
// instr pc_4 result dest mem_control reg_write store_data pc_offset stall_cycles
// store_data is compared for stores only, the last line ends the trace
20010005 00400004 00000005 01 0 1 00000000 0 0
2002fffd 00400008 fffffffd 02 0 1 00000000 0 0
00221820 0040000c 00000002 03 0 1 00000000 0 0
00612022 00400010 fffffffd 04 0 1 00000000 0 0
0081282a 00400014 00000001 05 0 1 00000000 0 0
2846fffc 00400018 00000000 06 0 1 00000000 0 0
342700f0 0040001c 000000f5 07 0 1 00000000 0 0
30e8003c 00400020 00000034 08 0 1 00000000 0 0
00e84826 00400024 000000c1 09 0 1 00000000 0 0
00205027 00400028 fffffffa 0a 0 1 00000000 0 0
00015900 0040002c 00000050 0b 0 1 00000000 0 0
000a6702 00400030 0000000f 0c 0 1 00000000 0 0
8c2d0008 00400034 0000000d 0d 2 1 00000000 0 0
01a17020 00400038 a5a5a5ad 0e 0 1 00000000 0 1
15c30004 0040003c a5a5a5af 00 0 0 00000000 1 2
200f7fff 00400040 00007fff 0f 0 1 00000000 0 0
00218020 00400044 0000000a 10 0 1 00000000 0 0
11e10002 00400048 00008004 00 0 0 00000000 0 1
10210003 0040004c 0000000a 00 0 0 00000000 1 0
08000040 00400050 00000100 00 0 0 00000000 0 0
0c000080 00400054 00400054 1f 0 1 00000000 0 0
ac3f0004 00400058 00000009 00 1 0 00400054 0 0
ac0e0000 0040005c 00000000 00 1 0 a5a5a5ad 0 0
03e08820 00400060 00400054 11 0 1 00000000 0 0
ffffffff

//--- tests/tb_id_ex.sv
`timescale 1ns/1ps
`include "pipeline_config.svh"

module tb_id_ex;
    import pipe_pkg::*;

    localparam int          trace_cols   = 9;          // values per trace line
    localparam int          max_lines    = 64;
    localparam logic [31:0] load_pattern = 32'hA5A5A5A5;  // load data is addr ^ pattern
    localparam logic [31:0] end_marker   = 32'hFFFFFFFF;

    // trace column order
    localparam int col_instr  = 0;
    localparam int col_pc_4   = 1;
    localparam int col_result = 2;
    localparam int col_dest   = 3;
    localparam int col_mem    = 4;
    localparam int col_we     = 5;
    localparam int col_store  = 6;
    localparam int col_pc_off = 7;
    localparam int col_stalls = 8;

    logic        clk;
    logic        rst_n;
    if_id_t      if_id;
    wb_t         wb = '0;
    ex_mem_t     ex_mem;
    logic        pc_offset;
    logic        stall;

    logic [31:0] trace_mem [0:trace_cols*max_lines-1];
    ex_mem_t     wb_pending;                           // bundle waiting for write-back
    int          issued_line;                          // line that left id, -1 when none
    int          id_ex_line;                           // line now held in id/ex
    int          num_lines;
    int          exp_idx;                              // trace results compared so far
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;

    id_ex_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_id     (if_id),
        .wb        (wb),
        .ex_mem    (ex_mem),
        .pc_offset (pc_offset),
        .stall     (stall)
    );

    always #4 clk = ~clk;                              // 8 ns period

    function automatic logic [31:0] trace_field(input int line, input int col);
        return trace_mem[line*trace_cols + col];
    endfunction

    // a bubble may only go where it cannot shorten an expected stall
    function automatic logic bubble_safe(input int line);
        if (trace_field(line, col_stalls) != 0)
            return 1'b0;
        if (line + 1 < num_lines && trace_field(line + 1, col_stalls) != 0)
            return 1'b0;
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string name, input int line,
                                   input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("Error: %s (trace line %0d) expected %h got %h", name, line, exp, got);
    endtask

    task automatic check_ex_mem(input int line, input ex_mem_t exp, input ex_mem_t got);
        checks++;
        if (got.valid !== exp.valid) begin
            report_mismatch("ex_mem.valid", line, 32'(exp.valid), 32'(got.valid));
        end else if (exp.valid) begin
            if (got.reg_write_enable !== exp.reg_write_enable)
                report_mismatch("ex_mem.reg_write_enable", line,
                                32'(exp.reg_write_enable), 32'(got.reg_write_enable));
            if (got.mem_control !== exp.mem_control)
                report_mismatch("ex_mem.mem_control", line, 32'(exp.mem_control),
                                32'(got.mem_control));
            if (got.dest_reg !== exp.dest_reg)
                report_mismatch("ex_mem.dest_reg", line, 32'(exp.dest_reg),
                                32'(got.dest_reg));
            if (got.result !== exp.result)
                report_mismatch("ex_mem.result", line, exp.result, got.result);
            if (exp.mem_control[mem_write_bit] && got.store_data !== exp.store_data)
                report_mismatch("ex_mem.store_data", line, exp.store_data, got.store_data);
        end
    endtask

    task automatic check_flag(input string name, input int line, input logic exp,
                              input logic got);
        checks++;
        if (got !== exp)
            report_mismatch(name, line, 32'(exp), 32'(got));
    endtask

    task automatic check_count(input string name, input int line, input int exp, input int got);
        checks++;
        if (got != exp)
            report_mismatch(name, line, 32'(exp), 32'(got));
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d errors", checks, errors);
    endtask

    // empty fetch slot with random contents that never stalls
    task automatic present_bubble();
        @(negedge clk);
        if_id.instruction = $urandom;
        if_id.pc_4        = $urandom;
        if_id.no_op       = 1'b1;
        #1;
        check_flag("stall", -1, 1'b0, stall);
    endtask

    // hold the line while stall is up, then count the stall cycles
    task automatic present_line(input int line);
        int stall_cycles;
        stall_cycles = 0;
        @(negedge clk);
        if_id.instruction = trace_field(line, col_instr);
        if_id.pc_4        = trace_field(line, col_pc_4);
        if_id.no_op       = 1'b0;
        #1;
        while (stall) begin
            stall_cycles++;
            @(negedge clk);                            // same if_id again
            #1;
        end
        issued_line = line;                            // taken at the next rising edge
        check_count("stall cycles", line, int'(trace_field(line, col_stalls)), stall_cycles);
    endtask

    // memory and write-back model one cycle behind ex_mem
    always @(negedge clk) begin
        if (!rst_n) begin
            wb         = '0;
            wb_pending = '0;
        end else begin
            wb.write_enable = wb_pending.valid && wb_pending.reg_write_enable;
            wb.dest_reg     = wb_pending.dest_reg;
            wb.data         = wb_pending.mem_control[mem_read_bit]
                            ? wb_pending.result ^ load_pattern : wb_pending.result;
            wb_pending      = ex_mem;
        end
    end

    // accepted lines move through id/ex and ex_mem, both checked every cycle
    always @(negedge clk) begin
        ex_mem_t exp;
        int      ex_line;
        logic    exp_offset;
        if (!rst_n) begin
            issued_line = -1;
            id_ex_line  = -1;
        end else begin
            ex_line     = id_ex_line;
            id_ex_line  = issued_line;
            issued_line = -1;
            exp         = '0;
            if (ex_line >= 0) begin
                exp.valid            = 1'b1;
                exp.reg_write_enable = trace_field(ex_line, col_we) != 0;
                exp.mem_control      = 2'(trace_field(ex_line, col_mem));
                exp.dest_reg         = `REGISTER_SIZE'(trace_field(ex_line, col_dest));
                exp.result           = trace_field(ex_line, col_result);
                exp.store_data       = trace_field(ex_line, col_store);
                exp_idx++;
            end
            check_ex_mem(ex_line, exp, ex_mem);
            exp_offset = 1'b0;                         // no taken branch without a line
            if (id_ex_line >= 0)
                exp_offset = trace_field(id_ex_line, col_pc_off) != 0;
            check_flag("pc_offset", id_ex_line, exp_offset, pc_offset);
        end
    end

    // run limit from the trace length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d results seen",
                     cycle_count, exp_idx, num_lines);
            print_summary();
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(22));
        clk            = 1'b0;
        rst_n          = 1'b0;
        if_id          = '0;
        if_id.no_op    = 1'b1;
        issued_line    = -1;
        id_ex_line     = -1;
        exp_idx        = 0;
        errors         = 0;
        checks         = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        num_lines      = 0;

        $readmemh("tests/id_ex_trace.txt", trace_mem);
        while (num_lines < max_lines && trace_field(num_lines, col_instr) != end_marker)
            num_lines++;
        if (num_lines == 0) begin
            errors++;
            $display("the trace file holds no lines");
        end
        cycle_limit = num_lines * 4 + 50;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        #1;
        check_flag("ex_mem.valid", -1, 1'b0, ex_mem.valid);   // idle after reset
        check_flag("pc_offset", -1, 1'b0, pc_offset);
        check_flag("stall", -1, 1'b0, stall);

        repeat (1 + $urandom % 3) present_bubble();

        for (int i = 0; i < num_lines; i++) begin
            if (bubble_safe(i) && $urandom % 4 == 0)
                present_bubble();
            present_line(i);
        end

        while (exp_idx < num_lines)
            present_bubble();                          // drain until every result is compared
        repeat (2) present_bubble();

        print_summary();
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
